// File: prim_pkg.sv
/*
 * Primitive renderer shared definitions.
 * Screen geometry, command opcodes and the packed structs that
 * carry commands, coordinates, walker points and VRAM writes.
 */

package prim_pkg;

    // screen geometry with two 8-bit pixels per 16-bit VRAM word
    localparam int VISIBLE_WIDTH  = 640;
    localparam int VISIBLE_HEIGHT = 480;
    localparam int DRAW_WIDTH     = VISIBLE_WIDTH / 2;  // half-width drawable area
    localparam int WORDS_PER_ROW  = DRAW_WIDTH / 2;
    localparam int CORDW          = 12;                 // signed coordinate width
    localparam int DEFAULT_HEIGHT = VISIBLE_HEIGHT / 2;

    // command field in the top nibble of a command word
    typedef enum logic [3:0] {
        PR_COORDX0     = 4'h0,
        PR_COORDY0     = 4'h1,
        PR_COORDX1     = 4'h2,
        PR_COORDY1     = 4'h3,
        PR_COLOR       = 4'h4,
        PR_DEST_ADDR   = 4'h5,
        PR_DEST_HEIGHT = 4'h6,
        PR_EXECUTE     = 4'hF
    } pr_reg_e;

    // primitive selected by the low nibble of an execute command
    typedef enum logic [3:0] {
        PR_LINE        = 4'h0,
        PR_FILLED_RECT = 4'h1
    } pr_prim_e;

    typedef struct packed {
        pr_reg_e     op;
        logic [11:0] value;
    } cmd_t;

    typedef struct packed {
        logic signed [CORDW-1:0] x;
        logic signed [CORDW-1:0] y;
    } point_t;

    typedef struct packed {
        point_t p0;
        point_t p1;
    } seg_t;

    typedef struct packed {
        logic [7:0]  colour;
        logic [15:0] dest_addr;     // word address of the frame buffer
        logic [11:0] dest_height;
    } draw_cfg_t;

    typedef struct packed {
        logic   drawing;
        logic   done;               // high with the last point
        point_t pt;
    } walk_t;

    typedef struct packed {
        logic        wr;
        logic [3:0]  mask;          // nibble write enables
        logic [15:0] addr;
        logic [15:0] data;
    } vram_wr_t;

endpackage

// File: prim_cmd_regs.sv
/*
 * Primitive renderer command registers.
 * Decodes host command strobes into coordinate and configuration
 * registers and turns an execute command into a start pulse.
 */

module prim_cmd_regs (
    input  logic                clk,
    input  logic                reset_i,
    input  prim_pkg::cmd_t      cmd_i,
    input  logic                cmd_valid_i,
    input  logic                busy_i,
    output prim_pkg::seg_t      seg_o,
    output prim_pkg::draw_cfg_t cfg_o,
    output logic                start_line_o,
    output logic                start_rect_o
);
    import prim_pkg::*;

    logic     launch_ok;    // no walker running or about to start
    pr_prim_e prim_sel;

    always_comb begin
        launch_ok = !busy_i && !start_line_o && !start_rect_o;
        prim_sel  = pr_prim_e'(cmd_i.value[3:0]);
    end

    always_ff @(posedge clk) begin
        start_line_o <= 1'b0;                   // pulses last one cycle
        start_rect_o <= 1'b0;
        if (reset_i) begin
            seg_o             <= '0;
            cfg_o.colour      <= '0;
            cfg_o.dest_addr   <= '0;
            cfg_o.dest_height <= 12'(DEFAULT_HEIGHT);
        end else if (cmd_valid_i) begin
            case (cmd_i.op)
                PR_COORDX0:     seg_o.p0.x        <= cmd_i.value;
                PR_COORDY0:     seg_o.p0.y        <= cmd_i.value;
                PR_COORDX1:     seg_o.p1.x        <= cmd_i.value;
                PR_COORDY1:     seg_o.p1.y        <= cmd_i.value;
                PR_COLOR:       cfg_o.colour      <= cmd_i.value[7:0];
                PR_DEST_ADDR:   cfg_o.dest_addr   <= {cmd_i.value, 4'b0000};
                PR_DEST_HEIGHT: cfg_o.dest_height <= cmd_i.value;
                PR_EXECUTE: begin
                    if (launch_ok) begin        // dropped while drawing
                        case (prim_sel)
                            PR_LINE:        start_line_o <= 1'b1;
                            PR_FILLED_RECT: start_rect_o <= 1'b1;
                            default:        ;   // unknown primitive
                        endcase
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

// File: draw_line.sv
/*
 * Bresenham line walker.
 * Steps from p0 to p1 inclusive, one point per enabled cycle,
 * using an integer error term in every octant.
 */

module draw_line (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            start_i,
    input  logic            oe_i,
    input  prim_pkg::seg_t  seg_i,
    output prim_pkg::walk_t walk_o,
    output logic            busy_o
);
    import prim_pkg::*;

    typedef enum logic [1:0] {IDLE, INIT, DRAW} line_state_e;

    line_state_e             state;
    logic signed [CORDW-1:0] x, y;
    logic signed [CORDW:0]   dx_raw, dy_raw;    // signed span p1 - p0
    logic signed [CORDW+1:0] dx, dy, err;       // dy kept negative
    logic signed [CORDW+1:0] err_cur, err_nxt;
    logic signed [CORDW+2:0] e2;
    logic signed [CORDW-1:0] x_nxt, y_nxt;
    logic                    x_dec, y_dec;      // step direction
    logic                    active, last;

    always_comb begin
        dx_raw  = seg_i.p1.x - seg_i.p0.x;
        dy_raw  = seg_i.p1.y - seg_i.p0.y;
        active  = (state != IDLE);
        last    = (x == seg_i.p1.x) && (y == seg_i.p1.y);
        err_cur = (state == INIT) ? dx + dy : err;  // error seeded on first point
        e2      = {err_cur, 1'b0};
        err_nxt = err_cur;
        x_nxt   = x;
        y_nxt   = y;
        if (e2 >= dy) begin
            x_nxt   = x_dec ? x - 1'b1 : x + 1'b1;
            err_nxt = err_nxt + dy;
        end
        if (e2 <= dx) begin
            y_nxt   = y_dec ? y - 1'b1 : y + 1'b1;
            err_nxt = err_nxt + dx;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state <= IDLE;
            x     <= '0;
            y     <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start_i) begin
                        x     <= seg_i.p0.x;
                        y     <= seg_i.p0.y;
                        state <= INIT;
                    end
                end
                INIT, DRAW: begin
                    if (!oe_i) begin
                        err   <= err_cur;           // hold point
                        state <= DRAW;
                    end else if (last) begin
                        x     <= '0;                // idle output must not disturb the merge
                        y     <= '0;
                        state <= IDLE;
                    end else begin
                        x     <= x_nxt;
                        y     <= y_nxt;
                        err   <= err_nxt;
                        state <= DRAW;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // spans and directions latched at start
    always_ff @(posedge clk) begin
        if (state == IDLE && start_i) begin
            dx    <= (dx_raw < 0) ? -dx_raw : dx_raw;
            dy    <= (dy_raw < 0) ? dy_raw : -dy_raw;
            x_dec <= (dx_raw < 0);
            y_dec <= (dy_raw < 0);
        end
    end

    always_comb begin
        busy_o         = active;
        walk_o.drawing = active && oe_i;
        walk_o.done    = active && oe_i && last;
        walk_o.pt.x    = x;
        walk_o.pt.y    = y;
    end

endmodule

// File: draw_rect_fill.sv
/*
 * Filled rectangle walker.
 * Scans rows from the lower to the higher y corner, each row from
 * the lower to the higher x corner, one point per enabled cycle.
 */

module draw_rect_fill (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            start_i,
    input  logic            oe_i,
    input  prim_pkg::seg_t  seg_i,
    output prim_pkg::walk_t walk_o,
    output logic            busy_o
);
    import prim_pkg::*;

    typedef enum logic {IDLE, SCAN} rect_state_e;

    rect_state_e             state;
    logic signed [CORDW-1:0] x, y;
    logic signed [CORDW-1:0] x_min, x_max, y_min, y_max;
    logic                    row_end, last;

    always_comb begin
        x_min   = (seg_i.p0.x < seg_i.p1.x) ? seg_i.p0.x : seg_i.p1.x;
        x_max   = (seg_i.p0.x < seg_i.p1.x) ? seg_i.p1.x : seg_i.p0.x;
        y_min   = (seg_i.p0.y < seg_i.p1.y) ? seg_i.p0.y : seg_i.p1.y;
        y_max   = (seg_i.p0.y < seg_i.p1.y) ? seg_i.p1.y : seg_i.p0.y;
        row_end = (x == x_max);
        last    = row_end && (y == y_max);
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state <= IDLE;
            x     <= '0;
            y     <= '0;
        end else if (state == IDLE) begin
            if (start_i) begin
                x     <= x_min;             // top left corner first
                y     <= y_min;
                state <= SCAN;
            end
        end else if (oe_i) begin
            if (last) begin
                x     <= '0;                // back to zero for the merge
                y     <= '0;
                state <= IDLE;
            end else if (row_end) begin
                x <= x_min;
                y <= y + 1'b1;
            end else begin
                x <= x + 1'b1;
            end
        end
    end

    always_comb begin
        busy_o         = (state == SCAN);
        walk_o.drawing = (state == SCAN) && oe_i;
        walk_o.done    = (state == SCAN) && oe_i && last;
        walk_o.pt.x    = x;
        walk_o.pt.y    = y;
    end

endmodule

// File: pixel_writer.sv
/*
 * Pixel writer.
 * Clips each walker point against the drawable area and forms a
 * registered VRAM write: word address, nibble mask and colour data.
 */

module pixel_writer (
    input  logic                clk,
    input  logic                reset_i,
    input  prim_pkg::walk_t     walk_i,
    input  prim_pkg::draw_cfg_t cfg_i,
    output prim_pkg::vram_wr_t  vram_o
);
    import prim_pkg::*;

    logic                 x_ok, y_ok, visible;
    logic signed [CORDW:0] height_s;    // height as a signed value
    logic [15:0]          row_off, col_off, addr;
    logic [3:0]           mask;

    always_comb begin
        height_s = $signed({1'b0, cfg_i.dest_height});
        x_ok     = (walk_i.pt.x >= 0) && (walk_i.pt.x < DRAW_WIDTH);
        y_ok     = (walk_i.pt.y >= 0) && (walk_i.pt.y < height_s);
        visible  = walk_i.drawing && x_ok && y_ok;

        // only meaningful once x and y are known to be non-negative
        row_off  = {4'b0000, walk_i.pt.y} * 16'(WORDS_PER_ROW);
        col_off  = {5'b00000, walk_i.pt.x[CORDW-1:1]};
        addr     = cfg_i.dest_addr + row_off + col_off;
        mask     = walk_i.pt.x[0] ? 4'b0011 : 4'b1100;  // odd pixel in low byte
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vram_o.wr <= 1'b0;
        end else begin
            vram_o.wr <= visible;   // clipped and idle cycles write nothing
        end
    end

    always_ff @(posedge clk) begin
        if (visible) begin
            vram_o.mask <= mask;
            vram_o.addr <= addr;
            vram_o.data <= {cfg_i.colour, cfg_i.colour};
        end
    end

endmodule

// File: prim_renderer.sv
/*
 * 2D primitive renderer top level.
 * Command registers start a line or a filled rectangle walker and
 * the pixel writer turns the merged points into VRAM writes.
 */

module prim_renderer (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               oe_i,
    input  prim_pkg::cmd_t     cmd_i,
    input  logic               cmd_valid_i,
    output prim_pkg::vram_wr_t vram_o,
    output logic               busy_o
);
    import prim_pkg::*;

    seg_t      seg;
    draw_cfg_t cfg;
    logic      start_line, start_rect;
    logic      busy_line, busy_rect;
    walk_t     walk_line, walk_rect, walk;

    prim_cmd_regs u_cmd_regs (
        .clk          (clk),
        .reset_i      (reset_i),
        .cmd_i        (cmd_i),
        .cmd_valid_i  (cmd_valid_i),
        .busy_i       (busy_o),
        .seg_o        (seg),
        .cfg_o        (cfg),
        .start_line_o (start_line),
        .start_rect_o (start_rect)
    );

    draw_line u_draw_line (
        .clk     (clk),
        .reset_i (reset_i),
        .start_i (start_line),
        .oe_i    (oe_i),
        .seg_i   (seg),
        .walk_o  (walk_line),
        .busy_o  (busy_line)
    );

    draw_rect_fill u_draw_rect (
        .clk     (clk),
        .reset_i (reset_i),
        .start_i (start_rect),
        .oe_i    (oe_i),
        .seg_i   (seg),
        .walk_o  (walk_rect),
        .busy_o  (busy_rect)
    );

    // idle walker outputs all zeros, so a plain OR merges them
    always_comb begin
        walk.drawing = walk_line.drawing | walk_rect.drawing;
        walk.done    = walk_line.done | walk_rect.done;
        walk.pt.x    = walk_line.pt.x | walk_rect.pt.x;
        walk.pt.y    = walk_line.pt.y | walk_rect.pt.y;
        busy_o       = busy_line | busy_rect;
    end

    pixel_writer u_pixel_writer (
        .clk     (clk),
        .reset_i (reset_i),
        .walk_i  (walk),
        .cfg_i   (cfg),
        .vram_o  (vram_o)
    );

endmodule

// File: prim_renderer_assert.sv
/*
 * Renderer protocol assertions.
 * Bound to the top level. Checks that writes follow busy, that masks
 * are legal and alternate within one word, that the last point ends
 * busy and that nothing is written in the cycles after reset.
 */

module prim_renderer_assert (
    input logic               clk,
    input logic               reset_i,
    input logic               busy_i,
    input prim_pkg::walk_t    walk_i,
    input prim_pkg::vram_wr_t vram_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // each write comes from a point drawn one cycle earlier
    write_follows_busy: assert property (
        @(posedge clk) disable iff (reset_i) vram_i.wr |-> $past(busy_i)
    ) else $error("VRAM write without busy_o in the previous cycle");

    // back to back writes to one word cover both of its pixels
    legal_mask: assert property (
        @(posedge clk) disable iff (reset_i)
        vram_i.wr |-> (vram_i.mask == 4'b0011 || vram_i.mask == 4'b1100) &&
            !($past(vram_i.wr) && vram_i.addr == $past(vram_i.addr) &&
              vram_i.mask == $past(vram_i.mask))
    ) else $error("VRAM write with illegal or repeated mask %b", vram_i.mask);

    // walker goes idle right after its last point
    done_ends_busy: assert property (
        @(posedge clk) disable iff (reset_i) walk_i.done |=> !busy_i
    ) else $error("busy_o still high after the last point");

    // no point can reach the writer within three cycles of reset
    no_write_after_reset: assert property (
        @(posedge clk) $past(reset_i, 3) |-> !vram_i.wr
    ) else $error("VRAM write right after reset");

endmodule

bind prim_renderer prim_renderer_assert u_assert (
    .clk     (clk),
    .reset_i (reset_i),
    .busy_i  (busy_o),
    .walk_i  (walk),
    .vram_i  (vram_o)
);

// File: tb_prim_renderer.sv
/*
 * Primitive renderer testbench.
 * Reads test lines from the cases file, sends the command words,
 * collects VRAM writes while drawing and compares count, address sum,
 * low byte writes and data with the expected values.
 */

module tb_prim_renderer;
    timeunit 1ns;
    timeprecision 100ps;
    import prim_pkg::*;

    localparam int TIMEOUT = 2000;  // cycles per wait

    logic        clk;
    logic        reset_i;
    logic        oe_i;
    cmd_t        cmd_i;
    logic        cmd_valid_i;
    vram_wr_t    vram_o;
    logic        busy_o;

    integer      seed;
    integer      rnd;
    logic        collect;           // writes belong to the current test
    logic        rand_oe;
    logic [15:0] exp_data;
    logic [15:0] cmd_words [8];
    int          wr_count, lo_count, err_count, addr_sum;
    int          pass_count, fail_count;

    prim_renderer UUT (
        .clk         (clk),
        .reset_i     (reset_i),
        .oe_i        (oe_i),
        .cmd_i       (cmd_i),
        .cmd_valid_i (cmd_valid_i),
        .vram_o      (vram_o),
        .busy_o      (busy_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rand_oe) begin
            rnd = $random(seed);
            oe_i <= rnd[0];
        end else begin
            oe_i <= 1'b1;               // walkers run freely
        end
    end

    // write monitor sampled mid cycle
    always @(negedge clk) begin
        if (collect && vram_o.wr) begin
            wr_count++;
            addr_sum += vram_o.addr;
            if (vram_o.mask == 4'b0011) begin
                lo_count++;             // odd x pixel
            end else if (vram_o.mask != 4'b1100) begin
                $display("[ERROR] %0t: mask %b at address %h",
                         $time, vram_o.mask, vram_o.addr);
                err_count++;
            end
            if (vram_o.data != exp_data) begin
                $display("[ERROR] %0t: data %h at address %h, expected %h",
                         $time, vram_o.data, vram_o.addr, exp_data);
                err_count++;
            end
        end
    end

    task automatic send_cmd(input logic [15:0] word);
        @(posedge clk);
        cmd_i       <= cmd_t'(word);
        cmd_valid_i <= 1'b1;
    endtask

    task automatic wait_busy(input logic level, output logic ok);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (busy_o != level && cycles < TIMEOUT);
        ok = (busy_o == level);
        if (!ok) begin
            $display("timeout: busy_o did not go %s within %0d cycles",
                     level ? "high" : "low", TIMEOUT);
        end
    endtask

    task automatic run_case(input string name, input int n, input int mode,
                            input int exp_count, input int exp_sum, input int exp_lo);
        logic rose, fell, good;
        int   i;
        @(posedge clk);
        wr_count  = 0;
        lo_count  = 0;
        err_count = 0;
        addr_sum  = 0;
        collect  <= 1'b1;
        rand_oe  <= (mode == 1);
        for (i = 0; i < n; i++) begin
            send_cmd(cmd_words[i]);
        end
        @(posedge clk);
        cmd_valid_i <= 1'b0;
        fell = 1'b0;
        wait_busy(1'b1, rose);
        if (rose) begin
            if (mode == 2) begin
                send_cmd(cmd_words[n-1]);   // execute again while drawing
                @(posedge clk);
                cmd_valid_i <= 1'b0;
            end
            wait_busy(1'b0, fell);          // last write shows up this cycle
        end
        @(posedge clk);
        collect <= 1'b0;
        rand_oe <= 1'b0;
        good = rose && fell && (err_count == 0);
        if (wr_count != exp_count) begin
            $display("[ERROR] %0t: %s wrote %0d pixels, expected %0d",
                     $time, name, wr_count, exp_count);
            good = 1'b0;
        end
        if (addr_sum != exp_sum) begin
            $display("[ERROR] %0t: %s address sum %0d, expected %0d",
                     $time, name, addr_sum, exp_sum);
            good = 1'b0;
        end
        if (lo_count != exp_lo) begin
            $display("[ERROR] %0t: %s low byte writes %0d, expected %0d",
                     $time, name, lo_count, exp_lo);
            good = 1'b0;
        end
        if (good) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("%s %s: %0d writes, address sum %0d",
                 good ? "PASS" : "FAIL", name, wr_count, addr_sum);
    endtask

    initial begin
        int    fd, r, n, mode, exp_count, exp_sum, exp_lo, i;
        string name, rest;
        seed        = 36;
        rand_oe     = 1'b0;
        collect     = 1'b0;
        pass_count  = 0;
        fail_count  = 0;
        reset_i     <= 1'b1;
        oe_i        <= 1'b1;
        cmd_i       <= '0;
        cmd_valid_i <= 1'b0;
        repeat (8) @(posedge clk);
        reset_i <= 1'b0;

        fd = $fopen("prim_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open prim_cases.txt");
            fail_count++;
        end else begin
            while (!$feof(fd)) begin
                r = $fscanf(fd, "%s", name);
                if (r != 1) break;
                if (name[0] == "#") begin
                    r = $fgets(rest, fd);   // column notes
                    continue;
                end
                r = $fscanf(fd, "%d", n);
                if (r != 1 || n < 1 || n > 8) begin
                    $display("bad command count for test %s in prim_cases.txt", name);
                    fail_count++;
                    break;
                end
                for (i = 0; i < n; i++) begin
                    r = $fscanf(fd, "%h", cmd_words[i]);
                end
                r = $fscanf(fd, "%d %d %d %d %h", mode, exp_count, exp_sum, exp_lo, exp_data);
                if (r != 5) begin
                    $display("missing expected values for test %s in prim_cases.txt", name);
                    fail_count++;
                    break;
                end
                run_case(name, n, mode, exp_count, exp_sum, exp_lo);
            end
            $fclose(fd);
        end

        $display("summary: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && pass_count > 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: prim_cases.txt
# name ncmd cmd_words(hex) mode writes addr_sum low_byte_writes data(hex)
# mode 0 holds oe_i high, 1 drives oe_i at random, 2 repeats the execute word while busy
# register state carries over from line to line
h_line 6 000A 1005 2014 3005 403C F000 0 11 8880 5 3C3C
diag_rev 6 001E 1014 2014 300A 4055 F000 0 11 26535 5 5555
steep 6 0064 1032 2067 303C 4081 F000 0 11 97356 5 8181
clip_line 6 0FFC 1006 2004 3002 400F F000 0 5 2244 2 0F0F
rect_rev 6 0007 1004 2004 3002 40A5 F001 0 12 5790 6 A5A5
clip_rect_x 6 013C 100A 2143 300B 4011 F001 0 8 14708 4 1111
clip_height 7 0000 1011 2003 3016 4077 6014 F001 0 12 34566 6 7777
base_addr 8 000A 1005 2014 3005 40C3 5100 60F0 F000 0 11 53936 5 C3C3
rand_oe_line 7 001E 1014 2014 300A 4055 5000 F000 1 11 26535 5 5555
rand_oe_rect 6 0007 1004 2004 3002 40A5 F001 1 12 5790 6 A5A5
busy_exec 6 000A 1005 2014 3005 403C F000 2 11 8880 5 3C3C

// File: sim.f
prim_pkg.sv
prim_cmd_regs.sv
draw_line.sv
draw_rect_fill.sv
pixel_writer.sv
prim_renderer.sv
prim_renderer_assert.sv
tb_prim_renderer.sv

// File: run_sim.sh
#!/bin/sh
# Build the primitive renderer testbench with Verilator and run it.
# Exits non-zero when the build or the run fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_prim_renderer -Mdir obj_dir -f sim.f > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/Vtb_prim_renderer > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" sim.log; then
    exit 1
fi
exit 0
